// File: verilog/nbody_pkg.sv
/*
 * N-body accelerator shared definitions
 * Widths, bus address regions, body memory row layout, memory request
 * format and the engine state encoding used across the design.
 */
package nbody_pkg;

    localparam int DATA_W     = 64;
    localparam int EXT_W      = 32;
    localparam int ADDR_W     = 16;
    localparam int BODY_IDX_W = 9;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [EXT_W-1:0]      ext_data_t;
    typedef logic [BODY_IDX_W-1:0] body_idx_t;

    // Upper address bits select a region, lower bits a body
    typedef enum logic [ADDR_W-BODY_IDX_W-1:0] {
        GO       = 7'h00,
        READ     = 7'h01,
        N_BODIES = 7'h02,
        GAP      = 7'h03,
        X_LO     = 7'h04,
        X_HI     = 7'h05,
        Y_LO     = 7'h06,
        Y_HI     = 7'h07,
        VX_LO    = 7'h0A,
        VX_HI    = 7'h0B,
        VY_LO    = 7'h0C,
        VY_HI    = 7'h0D,
        DONE     = 7'h40,
        RD_X_LO  = 7'h41,
        RD_X_HI  = 7'h42,
        RD_Y_LO  = 7'h43,
        RD_Y_HI  = 7'h44
    } region_e;

    // One bit per lane of a body row
    typedef logic [3:0] lane_mask_t;

    localparam lane_mask_t MASK_X  = 4'b0001;
    localparam lane_mask_t MASK_Y  = 4'b0010;
    localparam lane_mask_t MASK_VX = 4'b0100;
    localparam lane_mask_t MASK_VY = 4'b1000;

    typedef struct packed {
        data_t x;
        data_t y;
        data_t vx;
        data_t vy;
    } body_state_t;

    // Read uses idx, write uses wr_idx so a pipeline can do both per cycle
    typedef struct packed {
        logic        rd_en;
        body_idx_t   idx;
        body_idx_t   wr_idx;
        lane_mask_t  wr_mask;
        body_state_t wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        IDLE,
        READ_PASS,
        FINISH
    } run_state_e;

endpackage

// File: verilog/nbody_bus_regs.sv
/*
 * N-body bus register block
 * Decodes the memory-mapped bus, holds GO/READ/N_BODIES/GAP, stages the
 * lower half of 64-bit writes and turns half writes and position reads
 * into body memory requests. Read data is returned the cycle after a read.
 */
`timescale 1ns/1ps

module nbody_bus_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  chipselect_i,
    input  logic                  write_i,
    input  logic                  read_i,
    input  logic [nbody_pkg::ADDR_W-1:0] addr_i,
    input  nbody_pkg::ext_data_t  writedata_i,
    input  nbody_pkg::body_state_t mem_rsp_i,
    input  logic                  bus_granted_i,
    input  logic                  busy_i,
    input  logic                  done_i,
    output nbody_pkg::ext_data_t  readdata_o,
    output nbody_pkg::mem_req_t   bus_req_o,
    output logic                  go_o,
    output logic                  read_ack_o,
    output nbody_pkg::body_idx_t  n_bodies_o,
    output nbody_pkg::data_t      gap_o
);

    nbody_pkg::region_e   region;
    logic                 wr;
    logic                 rd;
    nbody_pkg::ext_data_t staged;
    nbody_pkg::data_t     full_word;
    logic                 rd_pending_q;
    nbody_pkg::region_e   rd_region_q;
    nbody_pkg::ext_data_t rd_sel;
    nbody_pkg::ext_data_t readdata_hold_q;

    assign region = nbody_pkg::region_e'(addr_i[nbody_pkg::ADDR_W-1:nbody_pkg::BODY_IDX_W]);
    assign wr     = chipselect_i & write_i;
    assign rd     = chipselect_i & read_i;

    // Control registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            go_o       <= 1'b0;
            read_ack_o <= 1'b0;
            n_bodies_o <= '0;
            gap_o      <= '0;
        end else if (wr) begin
            case (region)
                nbody_pkg::GO:   go_o       <= writedata_i[0];
                nbody_pkg::READ: read_ack_o <= writedata_i[0];
                // Run parameters are frozen while the engine is stepping
                nbody_pkg::N_BODIES: begin
                    if (!busy_i) begin
                        n_bodies_o <= writedata_i[nbody_pkg::BODY_IDX_W-1:0];
                    end
                end
                nbody_pkg::GAP: begin
                    if (!busy_i) begin
                        gap_o <= nbody_pkg::data_t'(writedata_i);
                    end
                end
                default: ;
            endcase
        end
    end

    // Lower half staging
    always_ff @(posedge clk) begin
        if (wr && (region == nbody_pkg::X_LO || region == nbody_pkg::Y_LO ||
                   region == nbody_pkg::VX_LO || region == nbody_pkg::VY_LO)) begin
            staged <= writedata_i;
        end
    end

    assign full_word = {writedata_i, staged};

    // Memory request from the bus side
    always_comb begin
        bus_req_o          = '0;
        bus_req_o.idx      = addr_i[nbody_pkg::BODY_IDX_W-1:0];
        bus_req_o.wr_idx   = addr_i[nbody_pkg::BODY_IDX_W-1:0];
        bus_req_o.wdata.x  = full_word;
        bus_req_o.wdata.y  = full_word;
        bus_req_o.wdata.vx = full_word;
        bus_req_o.wdata.vy = full_word;
        if (wr) begin
            case (region)
                nbody_pkg::X_HI:  bus_req_o.wr_mask = nbody_pkg::MASK_X;
                nbody_pkg::Y_HI:  bus_req_o.wr_mask = nbody_pkg::MASK_Y;
                nbody_pkg::VX_HI: bus_req_o.wr_mask = nbody_pkg::MASK_VX;
                nbody_pkg::VY_HI: bus_req_o.wr_mask = nbody_pkg::MASK_VY;
                default:          bus_req_o.wr_mask = '0;
            endcase
        end
        bus_req_o.rd_en = rd && (region == nbody_pkg::RD_X_LO || region == nbody_pkg::RD_X_HI ||
                                 region == nbody_pkg::RD_Y_LO || region == nbody_pkg::RD_Y_HI);
    end

    // Remember what was read so the answer lines up with the memory response
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_pending_q    <= 1'b0;
            rd_region_q     <= nbody_pkg::GO;
            readdata_hold_q <= '0;
        end else begin
            rd_pending_q <= rd;
            if (rd) begin
                rd_region_q <= region;
            end
            if (rd_pending_q) begin
                readdata_hold_q <= rd_sel;
            end
        end
    end

    always_comb begin
        case (rd_region_q)
            nbody_pkg::DONE:    rd_sel = nbody_pkg::ext_data_t'(done_i);
            nbody_pkg::RD_X_LO: rd_sel = mem_rsp_i.x[nbody_pkg::EXT_W-1:0];
            nbody_pkg::RD_X_HI: rd_sel = mem_rsp_i.x[nbody_pkg::DATA_W-1:nbody_pkg::EXT_W];
            nbody_pkg::RD_Y_LO: rd_sel = mem_rsp_i.y[nbody_pkg::EXT_W-1:0];
            nbody_pkg::RD_Y_HI: rd_sel = mem_rsp_i.y[nbody_pkg::DATA_W-1:nbody_pkg::EXT_W];
            default:            rd_sel = '1;
        endcase
        // A dropped position read reads as all ones
        if (rd_region_q != nbody_pkg::DONE && !bus_granted_i) begin
            rd_sel = '1;
        end
    end

    assign readdata_o = rd_pending_q ? rd_sel : readdata_hold_q;

endmodule

// File: verilog/body_mem_arbiter.sv
/*
 * Body memory arbiter
 * Fixed priority: the update engine owns the memory while busy, otherwise
 * the bus block does. The grant is registered so it lines up with the
 * memory response cycle.
 */
`timescale 1ns/1ps

module body_mem_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                eng_busy_i,
    input  nbody_pkg::mem_req_t eng_req_i,
    input  nbody_pkg::mem_req_t bus_req_i,
    output nbody_pkg::mem_req_t mem_req_o,
    output logic                bus_granted_o
);

    logic eng_active;

    assign eng_active = eng_req_i.rd_en | (|eng_req_i.wr_mask);

    // Bus requests are simply dropped while the engine runs
    assign mem_req_o = eng_busy_i ? eng_req_i : bus_req_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus_granted_o <= 1'b0;
        end else begin
            bus_granted_o <= !eng_busy_i;
        end
    end

    // Engine traffic outside busy would lose the memory to the bus
    a_eng_req_only_when_busy : assert property (
        @(posedge clk) disable iff (rst)
        eng_active |-> eng_busy_i
    ) else $error("engine request issued while engine not busy");

endmodule

// File: verilog/body_state_mem.sv
/*
 * Body state memory
 * BODIES rows of x, y, vx and vy. One registered read port and a write
 * port whose lanes are enabled individually by the request mask.
 */
`timescale 1ns/1ps

module body_state_mem #(
    parameter int BODIES = 512
) (
    input  logic                   clk,
    input  nbody_pkg::mem_req_t    mem_req_i,
    output nbody_pkg::body_state_t mem_rsp_o
);

    nbody_pkg::body_state_t mem [BODIES];

    always_ff @(posedge clk) begin
        if (|(mem_req_i.wr_mask & nbody_pkg::MASK_X)) begin
            mem[mem_req_i.wr_idx].x <= mem_req_i.wdata.x;
        end
        if (|(mem_req_i.wr_mask & nbody_pkg::MASK_Y)) begin
            mem[mem_req_i.wr_idx].y <= mem_req_i.wdata.y;
        end
        if (|(mem_req_i.wr_mask & nbody_pkg::MASK_VX)) begin
            mem[mem_req_i.wr_idx].vx <= mem_req_i.wdata.vx;
        end
        if (|(mem_req_i.wr_mask & nbody_pkg::MASK_VY)) begin
            mem[mem_req_i.wr_idx].vy <= mem_req_i.wdata.vy;
        end
        // Response shows up the cycle after the read
        if (mem_req_i.rd_en) begin
            mem_rsp_o <= mem[mem_req_i.idx];
        end
    end

    a_idx_in_range : assert property (
        @(posedge clk)
        (mem_req_i.rd_en |-> mem_req_i.idx < BODIES) and
        ((|mem_req_i.wr_mask) |-> mem_req_i.wr_idx < BODIES)
    ) else $error("body memory access out of range");

endmodule

// File: verilog/leapfrog_engine.sv
/*
 * Leapfrog position update engine
 * On GO, runs GAP passes over all bodies. Each pass reads one body per
 * cycle, adds velocity to position in the next cycle and writes the new
 * x and y one cycle later, so a pass takes n_bodies + 2 cycles.
 */
`timescale 1ns/1ps

module leapfrog_engine #(
    parameter int BODIES = 512
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   go_i,
    input  logic                   read_ack_i,
    input  nbody_pkg::body_idx_t   n_bodies_i,
    input  nbody_pkg::data_t       gap_i,
    input  nbody_pkg::body_state_t mem_rsp_i,
    output nbody_pkg::mem_req_t    eng_req_o,
    output logic                   busy_o,
    output logic                   done_o
);

    nbody_pkg::run_state_e state_q;
    logic                  rd_active_q;
    nbody_pkg::body_idx_t  rd_idx_q;
    nbody_pkg::body_idx_t  last_idx;
    nbody_pkg::data_t      step_cnt_q;
    logic                  last_step;
    logic                  s0_valid_q;
    logic                  s1_valid_q;
    nbody_pkg::body_idx_t  s0_idx_q;
    nbody_pkg::body_idx_t  s1_idx_q;
    nbody_pkg::data_t      sum_x_q;
    nbody_pkg::data_t      sum_y_q;
    logic                  pass_end;

    assign last_idx  = n_bodies_i - 1'b1;
    // GAP of zero still runs one step
    assign last_step = (step_cnt_q + 1'b1) >= gap_i;
    assign pass_end  = s1_valid_q && (s1_idx_q == last_idx);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= nbody_pkg::IDLE;
            rd_active_q <= 1'b0;
            rd_idx_q    <= '0;
            step_cnt_q  <= '0;
            s0_valid_q  <= 1'b0;
            s1_valid_q  <= 1'b0;
        end else begin
            s0_valid_q <= rd_active_q;
            s1_valid_q <= s0_valid_q;
            case (state_q)
                nbody_pkg::IDLE: begin
                    if (go_i && !read_ack_i) begin
                        step_cnt_q <= '0;
                        rd_idx_q   <= '0;
                        // Nothing to move with no bodies
                        if (n_bodies_i == '0) begin
                            state_q <= nbody_pkg::FINISH;
                        end else begin
                            state_q     <= nbody_pkg::READ_PASS;
                            rd_active_q <= 1'b1;
                        end
                    end
                end
                nbody_pkg::READ_PASS: begin
                    if (!go_i) begin
                        state_q     <= nbody_pkg::IDLE;
                        rd_active_q <= 1'b0;
                        s0_valid_q  <= 1'b0;
                        s1_valid_q  <= 1'b0;
                    end else begin
                        if (rd_active_q) begin
                            if (rd_idx_q == last_idx) begin
                                rd_active_q <= 1'b0;
                            end else begin
                                rd_idx_q <= rd_idx_q + 1'b1;
                            end
                        end
                        // Last write retires this cycle
                        if (pass_end) begin
                            if (last_step) begin
                                state_q <= nbody_pkg::FINISH;
                            end else begin
                                step_cnt_q  <= step_cnt_q + 1'b1;
                                rd_idx_q    <= '0;
                                rd_active_q <= 1'b1;
                            end
                        end
                    end
                end
                nbody_pkg::FINISH: begin
                    if (read_ack_i || !go_i) begin
                        state_q <= nbody_pkg::IDLE;
                    end
                end
                default: state_q <= nbody_pkg::IDLE;
            endcase
        end
    end

    // Index pipeline and adders
    always_ff @(posedge clk) begin
        s0_idx_q <= rd_idx_q;
        s1_idx_q <= s0_idx_q;
        sum_x_q  <= mem_rsp_i.x + mem_rsp_i.vx;
        sum_y_q  <= mem_rsp_i.y + mem_rsp_i.vy;
    end

    always_comb begin
        eng_req_o         = '0;
        eng_req_o.rd_en   = rd_active_q;
        eng_req_o.idx     = rd_idx_q;
        eng_req_o.wr_idx  = s1_idx_q;
        eng_req_o.wr_mask = s1_valid_q ? (nbody_pkg::MASK_X | nbody_pkg::MASK_Y) : '0;
        eng_req_o.wdata.x = sum_x_q;
        eng_req_o.wdata.y = sum_y_q;
    end

    assign busy_o = (state_q == nbody_pkg::READ_PASS);
    assign done_o = (state_q == nbody_pkg::FINISH);

    // Writes come only from bodies read during the current pass
    a_write_in_pass : assert property (
        @(posedge clk) disable iff (rst)
        (|eng_req_o.wr_mask) |->
            (state_q == nbody_pkg::READ_PASS) && (eng_req_o.wr_idx < BODIES)
    ) else $error("engine write outside a position pass");

endmodule

// File: verilog/nbody_top.sv
/*
 * N-body accelerator top level
 * Bus register block and leapfrog engine share the body memory
 * through a fixed-priority arbiter.
 */
`timescale 1ns/1ps

module nbody_top #(
    parameter int BODIES = 512
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         chipselect_i,
    input  logic                         write_i,
    input  logic                         read_i,
    input  logic [nbody_pkg::ADDR_W-1:0] addr_i,
    input  nbody_pkg::ext_data_t         writedata_i,
    output nbody_pkg::ext_data_t         readdata_o
);

    nbody_pkg::mem_req_t    bus_req;
    nbody_pkg::mem_req_t    eng_req;
    nbody_pkg::mem_req_t    mem_req;
    nbody_pkg::body_state_t mem_rsp;
    logic                   bus_granted;
    logic                   go;
    logic                   read_ack;
    nbody_pkg::body_idx_t   n_bodies;
    nbody_pkg::data_t       gap;
    logic                   busy;
    logic                   done;

    nbody_bus_regs i_bus_regs (
        .clk           (clk),
        .rst           (rst),
        .chipselect_i  (chipselect_i),
        .write_i       (write_i),
        .read_i        (read_i),
        .addr_i        (addr_i),
        .writedata_i   (writedata_i),
        .mem_rsp_i     (mem_rsp),
        .bus_granted_i (bus_granted),
        .busy_i        (busy),
        .done_i        (done),
        .readdata_o    (readdata_o),
        .bus_req_o     (bus_req),
        .go_o          (go),
        .read_ack_o    (read_ack),
        .n_bodies_o    (n_bodies),
        .gap_o         (gap)
    );

    leapfrog_engine #(
        .BODIES (BODIES)
    ) i_engine (
        .clk        (clk),
        .rst        (rst),
        .go_i       (go),
        .read_ack_i (read_ack),
        .n_bodies_i (n_bodies),
        .gap_i      (gap),
        .mem_rsp_i  (mem_rsp),
        .eng_req_o  (eng_req),
        .busy_o     (busy),
        .done_o     (done)
    );

    body_mem_arbiter i_arbiter (
        .clk           (clk),
        .rst           (rst),
        .eng_busy_i    (busy),
        .eng_req_i     (eng_req),
        .bus_req_i     (bus_req),
        .mem_req_o     (mem_req),
        .bus_granted_o (bus_granted)
    );

    body_state_mem #(
        .BODIES (BODIES)
    ) i_mem (
        .clk       (clk),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

endmodule

// File: verif/tb_clock.sv
/*
 * Testbench clock and reset generator
 * 4 ns clock, reset held high for the first 5 cycles.
 */
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Release away from the rising edge
    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// File: verif/nbody_tb.sv
/*
 * N-body accelerator testbench
 * Directed tests over the memory-mapped bus: load and readback, single
 * and multi-step position updates, the GO/READ/DONE handshake, the body
 * count bound and unmapped reads. Inputs change on the falling edge.
 */
`timescale 1ns/1ps

module nbody_tb;

    localparam int BODIES  = 512;
    localparam int N_MAIN  = 8;
    localparam int N_BOUND = 6;
    // Engine cycles of all runs, gap x (n_bodies + 2) each
    localparam int RUN_CYCLES = 1 * (N_MAIN + 2) + 5 * (N_MAIN + 2)
                              + 2 * 3 * (N_MAIN + 2) + 2 * (N_BOUND + 2);
    localparam int WATCHDOG_CYCLES = 4 * RUN_CYCLES + 2000;

    logic        clk;
    logic        rst;
    logic        chipselect;
    logic        write_en;
    logic        read_en;
    logic [15:0] addr;
    logic [31:0] writedata;
    logic [31:0] readdata;

    logic [63:0] x0 [8];
    logic [63:0] y0 [8];
    logic [63:0] vx [8];
    logic [63:0] vy [8];
    logic [31:0] lfsr_state = 32'd71778;

    tb_clock i_clock (
        .clk_o (clk),
        .rst_o (rst)
    );

    nbody_top #(
        .BODIES (BODIES)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .chipselect_i (chipselect),
        .write_i      (write_en),
        .read_i       (read_en),
        .addr_i       (addr),
        .writedata_i  (writedata),
        .readdata_o   (readdata)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_bits(input int nbits, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[62:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [15:0] bus_addr(input logic [6:0] region, input int idx);
        return {region, nbody_pkg::body_idx_t'(idx)};
    endfunction

    task automatic check(input string test_name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected %h, actual %h", test_name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic bus_write(input logic [6:0] region, input int idx, input logic [31:0] data);
        @(negedge clk);
        chipselect = 1'b1;
        write_en   = 1'b1;
        addr       = bus_addr(region, idx);
        writedata  = data;
        @(negedge clk);
        chipselect = 1'b0;
        write_en   = 1'b0;
    endtask

    // Answer is valid one cycle after the request
    task automatic bus_read(input logic [6:0] region, input int idx, output logic [31:0] data);
        @(negedge clk);
        chipselect = 1'b1;
        read_en    = 1'b1;
        addr       = bus_addr(region, idx);
        @(negedge clk);
        data       = readdata;
        chipselect = 1'b0;
        read_en    = 1'b0;
    endtask

    task automatic load_body(input int idx);
        bus_write(nbody_pkg::X_LO, idx, x0[idx][31:0]);
        bus_write(nbody_pkg::X_HI, idx, x0[idx][63:32]);
        bus_write(nbody_pkg::Y_LO, idx, y0[idx][31:0]);
        bus_write(nbody_pkg::Y_HI, idx, y0[idx][63:32]);
        bus_write(nbody_pkg::VX_LO, idx, vx[idx][31:0]);
        bus_write(nbody_pkg::VX_HI, idx, vx[idx][63:32]);
        bus_write(nbody_pkg::VY_LO, idx, vy[idx][31:0]);
        bus_write(nbody_pkg::VY_HI, idx, vy[idx][63:32]);
    endtask

    task automatic read_position(input int idx, output logic [63:0] x, output logic [63:0] y);
        logic [31:0] lo;
        logic [31:0] hi;
        bus_read(nbody_pkg::RD_X_LO, idx, lo);
        bus_read(nbody_pkg::RD_X_HI, idx, hi);
        x = {hi, lo};
        bus_read(nbody_pkg::RD_Y_LO, idx, lo);
        bus_read(nbody_pkg::RD_Y_HI, idx, hi);
        y = {hi, lo};
    endtask

    task automatic randomize_bodies(input int count);
        logic [63:0] r;
        for (int i = 0; i < count; i++) begin
            random_bits(64, r);
            x0[i] = r;
            random_bits(64, r);
            y0[i] = r;
            random_bits(64, r);
            vx[i] = r;
            random_bits(64, r);
            vy[i] = r;
            load_body(i);
        end
    endtask

    task automatic wait_done();
        logic [31:0] status;
        status = '0;
        while (status[0] !== 1'b1) begin
            bus_read(nbody_pkg::DONE, 0, status);
        end
    endtask

    task automatic start_run(input int n_bodies, input int gap);
        bus_write(nbody_pkg::N_BODIES, 0, n_bodies);
        bus_write(nbody_pkg::GAP, 0, gap);
        bus_write(nbody_pkg::GO, 0, 32'd1);
    endtask

    // Expected position after a number of steps, wrapping mod 2^64
    task automatic check_positions(input string test_name, input int first, input int count,
                                   input int steps);
        logic [63:0] x;
        logic [63:0] y;
        for (int i = first; i < first + count; i++) begin
            read_position(i, x, y);
            check($sformatf("%s x%0d", test_name, i), x0[i] + vx[i] * 64'(steps), x);
            check($sformatf("%s y%0d", test_name, i), y0[i] + vy[i] * 64'(steps), y);
        end
    endtask

    task automatic load_and_readback();
        randomize_bodies(N_MAIN);
        check_positions("load_readback", 0, N_MAIN, 0);
    endtask

    task automatic single_step_update();
        randomize_bodies(N_MAIN);
        // Force wraps in both directions
        x0[0] = 64'hFFFF_FFFF_FFFF_FFF0;
        vx[0] = 64'h0000_0000_0000_0040;
        y0[1] = 64'h0000_0000_0000_0010;
        vy[1] = 64'hFFFF_FFFF_FFFF_FF00;
        load_body(0);
        load_body(1);
        start_run(N_MAIN, 1);
        wait_done();
        check_positions("single_step", 0, N_MAIN, 1);
        bus_write(nbody_pkg::GO, 0, 32'd0);
    endtask

    task automatic multi_step_update();
        randomize_bodies(N_MAIN);
        start_run(N_MAIN, 5);
        wait_done();
        check_positions("multi_step", 0, N_MAIN, 5);
        bus_write(nbody_pkg::GO, 0, 32'd0);
    endtask

    task automatic run_handshake();
        logic [31:0] status;
        randomize_bodies(N_MAIN);
        start_run(N_MAIN, 3);
        wait_done();
        check_positions("handshake_first", 0, N_MAIN, 3);
        bus_write(nbody_pkg::READ, 0, 32'd1);
        bus_read(nbody_pkg::DONE, 0, status);
        check("handshake_done_low", 64'd0, 64'(status));
        // READ held high keeps the engine idle
        repeat (100) @(negedge clk);
        check_positions("handshake_hold", 0, N_MAIN, 3);
        bus_write(nbody_pkg::READ, 0, 32'd0);
        wait_done();
        check_positions("handshake_second", 0, N_MAIN, 6);
        bus_write(nbody_pkg::GO, 0, 32'd0);
    endtask

    task automatic bound_and_unmapped();
        logic [31:0] data;
        randomize_bodies(N_BOUND + 1);
        start_run(N_BOUND, 2);
        wait_done();
        check_positions("bounds_moved", 0, N_BOUND, 2);
        check_positions("bounds_outside", N_BOUND, 1, 0);
        bus_write(nbody_pkg::GO, 0, 32'd0);
        bus_read(7'h20, 0, data);
        check("unmapped_read", 64'hFFFF_FFFF, 64'(data));
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: timeout waiting for DONE");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        chipselect = 1'b0;
        write_en   = 1'b0;
        read_en    = 1'b0;
        addr       = '0;
        writedata  = '0;
        wait (rst == 1'b0);
        @(negedge clk);
        load_and_readback();
        single_step_update();
        multi_step_update();
        run_handshake();
        bound_and_unmapped();
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: sources.f
verilog/nbody_pkg.sv
verilog/nbody_bus_regs.sv
verilog/body_mem_arbiter.sv
verilog/body_state_mem.sv
verilog/leapfrog_engine.sv
verilog/nbody_top.sv
verif/tb_clock.sv
verif/nbody_tb.sv

// File: Bender.yml
package:
  name: nbody_accel

sources:
  - verilog/nbody_pkg.sv
  - verilog/nbody_bus_regs.sv
  - verilog/body_mem_arbiter.sv
  - verilog/body_state_mem.sv
  - verilog/leapfrog_engine.sv
  - verilog/nbody_top.sv

  - target: simulation
    files:
      - verif/tb_clock.sv
      - verif/nbody_tb.sv
